// ==== hw/bimodal_predictor.sv ====
// Bimodal table of 2-bit saturating counters, indexed by the line bits of a PC.
// The read is synchronous. The update writes one step from upd_ctr_i, not from
// the stored value, so the caller chooses the starting point.
`timescale 1ns/1ps
`default_nettype none

module bimodal_predictor
    import bpu_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst_n_i,

    input  wire [ADDR_WIDTH-1:0] query_pc_i,
    output logic [1:0]           ctr_o,

    input  wire                  upd_valid_i,
    input  wire [ADDR_WIDTH-1:0] upd_pc_i,
    input  wire                  upd_taken_i,
    input  wire [1:0]            upd_ctr_i
);

    logic [1:0]               ctr_q [BIM_DEPTH];
    logic [BIM_IDX_WIDTH-1:0] query_idx;
    logic [BIM_IDX_WIDTH-1:0] upd_idx;
    logic [1:0]               ctr_next;

    assign query_idx = query_pc_i[LINE_OFFSET +: BIM_IDX_WIDTH];
    assign upd_idx   = upd_pc_i[LINE_OFFSET +: BIM_IDX_WIDTH];

    // Saturate one step toward the resolved direction
    always_comb begin
        if (upd_taken_i) begin
            ctr_next = (upd_ctr_i == 2'd3) ? 2'd3 : upd_ctr_i + 2'd1;
        end else begin
            ctr_next = (upd_ctr_i == 2'd0) ? 2'd0 : upd_ctr_i - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < BIM_DEPTH; i++) begin
                ctr_q[i] <= CTR_WEAK_NOT_TAKEN;
            end
            ctr_o <= CTR_WEAK_NOT_TAKEN;
        end else begin
            ctr_o <= ctr_q[query_idx];
            if (upd_valid_i) begin
                ctr_q[upd_idx] <= ctr_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/bpu.sv ====
// Two-stage branch prediction unit. S0 holds the fetch PC and looks it up in the
// FTB and the bimodal table; S1 forms a block from the results one cycle later.
// S0 always guesses the next line, so a taken prediction costs one bubble.
// A training mispredict has priority over everything and kills S1.
`timescale 1ns/1ps
`default_nettype none

module bpu
    import bpu_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n_i,

    output fetch_block_t blk_o,
    output pred_meta_t   meta_o,
    input  wire          blk_ready_i,

    input  train_t       train_i
);

    logic [ADDR_WIDTH-1:0] s0_pc;
    logic [ADDR_WIDTH-1:0] s1_pc;
    logic                  s1_valid;
    logic                  s1_load;
    logic [ADDR_WIDTH-1:0] query_pc;

    logic                  ftb_hit;
    ftb_entry_t            ftb_entry;
    logic [1:0]            ctr;

    logic [BLK_LEN_WIDTH-1:0] start_slot;
    logic [BLK_LEN_WIDTH-1:0] br_slot;
    logic                     br_in_blk;
    logic                     pred_taken;
    logic                     redirect;

    //////////////////////////////////////////////////
    // S0 and pipeline control
    //////////////////////////////////////////////////
    // S1 takes a new PC when empty or when its block is accepted
    assign s1_load  = !s1_valid || blk_ready_i;
    assign redirect = train_i.valid && train_i.mispredict;

    // On a stall, look up the S1 PC again so the table outputs stay aligned
    assign query_pc = s1_load ? s0_pc : s1_pc;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            s0_pc    <= RESET_PC;
            s1_valid <= 1'b0;
        end else if (redirect) begin
            s0_pc    <= train_i.redirect_pc;
            s1_valid <= 1'b0;
        end else if (s1_valid && blk_ready_i && pred_taken) begin
            // Drop the speculative next line
            s0_pc    <= ftb_entry.target;
            s1_valid <= 1'b0;
        end else if (s1_load) begin
            s0_pc    <= next_line(s0_pc);
            s1_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_load) begin
            s1_pc <= s0_pc;
        end
    end

    //////////////////////////////////////////////////
    // S1 block formation
    //////////////////////////////////////////////////
    assign start_slot = BLK_LEN_WIDTH'(s1_pc[LINE_OFFSET-1:2]);
    assign br_slot    = BLK_LEN_WIDTH'(ftb_entry.branch_pc[LINE_OFFSET-1:2]);
    // Tag match already places the branch in this line
    assign br_in_blk  = ftb_hit && (br_slot >= start_slot);
    assign pred_taken = br_in_blk && ctr[1];

    always_comb begin
        blk_o.valid           = s1_valid;
        blk_o.start_pc        = s1_pc;
        blk_o.predicted_taken = pred_taken;
        if (pred_taken) begin
            blk_o.length  = br_slot - start_slot + 1'b1;
            blk_o.next_pc = ftb_entry.target;
        end else begin
            blk_o.length  = BLK_LEN_WIDTH'(FETCH_WIDTH) - start_slot;
            blk_o.next_pc = next_line(s1_pc);
        end
        meta_o.ftb_hit   = br_in_blk;
        meta_o.ctr       = ctr;
        meta_o.branch_pc = ftb_entry.branch_pc;
        meta_o.target    = ftb_entry.target;
    end

    //////////////////////////////////////////////////
    // Tables and training
    //////////////////////////////////////////////////
    ftb_entry_t ftb_upd;

    always_comb begin
        ftb_upd.valid     = 1'b1;
        ftb_upd.tag       = train_i.branch_pc[ADDR_WIDTH-1 -: FTB_TAG_WIDTH];
        ftb_upd.branch_pc = train_i.branch_pc;
        ftb_upd.target    = train_i.target;
    end

    ftb u_ftb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .query_pc_i  (query_pc),
        .hit_o       (ftb_hit),
        .entry_o     (ftb_entry),
        .upd_valid_i (redirect),
        .upd_entry_i (ftb_upd)
    );

    // Untrained branches start from weakly taken
    bimodal_predictor u_bim (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .query_pc_i  (query_pc),
        .ctr_o       (ctr),
        .upd_valid_i (train_i.valid && (train_i.ftb_hit || train_i.mispredict)),
        .upd_pc_i    (train_i.branch_pc),
        .upd_taken_i (train_i.is_taken),
        .upd_ctr_i   (train_i.ftb_hit ? train_i.ctr : CTR_WEAK_TAKEN)
    );

endmodule

`default_nettype wire

// ==== hw/bpu_pkg.sv ====
// Shared sizes, reset PC and packed structs for the branch-predicting front end.
// Blocks never cross a 16-byte line, so one block holds at most FETCH_WIDTH words.
// The FTB and the bimodal table are both indexed by the line bits of a PC.
`default_nettype none

package bpu_pkg;

    //////////////////////////////////////////////////
    // Sizes and constants
    //////////////////////////////////////////////////
    localparam int ADDR_WIDTH      = 32;
    localparam int FETCH_WIDTH     = 4;
    localparam int FTB_DEPTH       = 64;
    localparam int BIM_DEPTH       = 256;
    localparam int FTQ_DEPTH       = 8;

    localparam logic [ADDR_WIDTH-1:0] RESET_PC = 32'h0000_1000;

    localparam logic [1:0] CTR_WEAK_TAKEN     = 2'd2;
    localparam logic [1:0] CTR_WEAK_NOT_TAKEN = 2'd1;

    // Derived widths
    localparam int INSTR_IDX_WIDTH = $clog2(FETCH_WIDTH);
    localparam int LINE_OFFSET     = INSTR_IDX_WIDTH + 2;
    localparam int BLK_LEN_WIDTH   = INSTR_IDX_WIDTH + 1;
    localparam int FTB_IDX_WIDTH   = $clog2(FTB_DEPTH);
    localparam int FTB_TAG_WIDTH   = 24;
    localparam int BIM_IDX_WIDTH   = $clog2(BIM_DEPTH);
    localparam int FTQ_IDX_WIDTH   = $clog2(FTQ_DEPTH);

    //////////////////////////////////////////////////
    // Packed structs
    //////////////////////////////////////////////////
    typedef struct packed {
        logic                     valid;
        logic [ADDR_WIDTH-1:0]    start_pc;
        logic [BLK_LEN_WIDTH-1:0] length;
        logic                     predicted_taken;
        logic [ADDR_WIDTH-1:0]    next_pc;
    } fetch_block_t;

    typedef struct packed {
        logic                  ftb_hit;
        logic [1:0]            ctr;
        logic [ADDR_WIDTH-1:0] branch_pc;
        logic [ADDR_WIDTH-1:0] target;
    } pred_meta_t;

    typedef struct packed {
        logic                  has_branch;
        logic [ADDR_WIDTH-1:0] branch_pc;
        logic                  is_taken;
        logic [ADDR_WIDTH-1:0] target;
    } resolve_t;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] branch_pc;
        logic                  is_taken;
        logic [ADDR_WIDTH-1:0] target;
        logic [1:0]            ctr;
        logic                  ftb_hit;
        logic                  mispredict;
        logic [ADDR_WIDTH-1:0] redirect_pc;
    } train_t;

    typedef struct packed {
        logic                     valid;
        logic [FTB_TAG_WIDTH-1:0] tag;
        logic [ADDR_WIDTH-1:0]    branch_pc;
        logic [ADDR_WIDTH-1:0]    target;
    } ftb_entry_t;

    // Start of the 16-byte line after the one holding pc
    function automatic logic [ADDR_WIDTH-1:0] next_line(input logic [ADDR_WIDTH-1:0] pc);
        next_line = {pc[ADDR_WIDTH-1:LINE_OFFSET] + 1'b1, {LINE_OFFSET{1'b0}}};
    endfunction

endpackage

`default_nettype wire

// ==== hw/frontend_top.sv ====
// Front end top: prediction unit feeding the fetch target queue.
// Only the four-phase fetch and resolve ports leave this level.
`timescale 1ns/1ps
`default_nettype none

module frontend_top
    import bpu_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n_i,

    output logic         fetch_req_o,
    input  wire          fetch_ack_i,
    output fetch_block_t fetch_blk_o,

    input  wire          resolve_req_i,
    input  resolve_t     resolve_i,
    output logic         resolve_ack_o
);

    fetch_block_t blk;
    pred_meta_t   meta;
    logic         blk_ready;
    train_t       train;

    bpu u_bpu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .blk_o       (blk),
        .meta_o      (meta),
        .blk_ready_i (blk_ready),
        .train_i     (train)
    );

    ftq u_ftq (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .blk_i         (blk),
        .meta_i        (meta),
        .blk_ready_o   (blk_ready),
        .fetch_req_o   (fetch_req_o),
        .fetch_ack_i   (fetch_ack_i),
        .fetch_blk_o   (fetch_blk_o),
        .resolve_req_i (resolve_req_i),
        .resolve_i     (resolve_i),
        .resolve_ack_o (resolve_ack_o),
        .train_o       (train)
    );

endmodule

`default_nettype wire

// ==== hw/ftb.sv ====
// Direct-mapped fetch target buffer, one conditional branch per 16-byte line.
// The read is synchronous. hit_o and entry_o belong to the PC of the previous cycle.
// A write and a read of the same index in one cycle return the old entry.
`timescale 1ns/1ps
`default_nettype none

module ftb
    import bpu_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n_i,

    // Lookup
    input  wire  [ADDR_WIDTH-1:0] query_pc_i,
    output logic                  hit_o,
    output ftb_entry_t            entry_o,

    // Training write
    input  wire                   upd_valid_i,
    input  ftb_entry_t            upd_entry_i
);

    ftb_entry_t             mem [FTB_DEPTH];
    logic [FTB_DEPTH-1:0]   vld;

    logic [FTB_IDX_WIDTH-1:0] query_idx;
    logic [FTB_IDX_WIDTH-1:0] upd_idx;
    logic [FTB_TAG_WIDTH-1:0] query_tag_q;
    ftb_entry_t               entry_q;
    logic                     vld_q;

    assign query_idx = query_pc_i[LINE_OFFSET +: FTB_IDX_WIDTH];
    assign upd_idx   = upd_entry_i.branch_pc[LINE_OFFSET +: FTB_IDX_WIDTH];

    // Valid bits and the registered valid of the lookup
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vld   <= '0;
            vld_q <= 1'b0;
        end else begin
            vld_q <= vld[query_idx];
            if (upd_valid_i) begin
                vld[upd_idx] <= upd_entry_i.valid;
            end
        end
    end

    // Entry storage and read data
    always_ff @(posedge clk) begin
        entry_q     <= mem[query_idx];
        query_tag_q <= query_pc_i[ADDR_WIDTH-1 -: FTB_TAG_WIDTH];
        if (upd_valid_i) begin
            mem[upd_idx] <= upd_entry_i;
        end
    end

    // Tag compare against the registered query PC
    assign hit_o = vld_q && (entry_q.tag == query_tag_q);

    always_comb begin
        entry_o       = entry_q;
        entry_o.valid = vld_q;
    end

endmodule

`default_nettype wire

// ==== hw/ftq.sv ====
// Circular fetch target queue with write, fetch and commit pointers.
// Fetch and resolve are four-phase ports. A resolve ack is held off while a fetch
// request is up, so a flush never lands inside a fetch handshake.
// train_o is combinational and valid only in the cycle before resolve_ack_o rises.
`timescale 1ns/1ps
`default_nettype none

module ftq
    import bpu_pkg::*;
(
    input  wire          clk,
    input  wire          rst_n_i,

    // From the prediction unit
    input  fetch_block_t blk_i,
    input  pred_meta_t   meta_i,
    output logic         blk_ready_o,

    // Fetch port
    output logic         fetch_req_o,
    input  wire          fetch_ack_i,
    output fetch_block_t fetch_blk_o,

    // Resolve port
    input  wire          resolve_req_i,
    input  resolve_t     resolve_i,
    output logic         resolve_ack_o,
    output train_t       train_o
);

    fetch_block_t blk_q  [FTQ_DEPTH];
    pred_meta_t   meta_q [FTQ_DEPTH];

    // Extra top bit tells full from empty
    logic [FTQ_IDX_WIDTH:0] wr_ptr, fe_ptr, cm_ptr;

    logic         blk_wr;
    logic         fetch_start;
    logic         resolve_start;
    logic         flush;
    logic         actual_taken;
    logic         mispredict;
    fetch_block_t res_blk;
    pred_meta_t   res_meta;

    assign blk_ready_o = !((wr_ptr[FTQ_IDX_WIDTH] != cm_ptr[FTQ_IDX_WIDTH]) &&
                           (wr_ptr[FTQ_IDX_WIDTH-1:0] == cm_ptr[FTQ_IDX_WIDTH-1:0]));

    assign resolve_start = resolve_req_i && !resolve_ack_o && !fetch_req_o &&
                           (cm_ptr != fe_ptr);
    assign fetch_start   = !fetch_req_o && !fetch_ack_i && (fe_ptr != wr_ptr) &&
                           !resolve_start;
    assign flush         = resolve_start && mispredict;
    assign blk_wr        = blk_i.valid && blk_ready_o && !flush;

    //////////////////////////////////////////////////
    // Resolution against stored prediction
    //////////////////////////////////////////////////
    assign res_blk      = blk_q[cm_ptr[FTQ_IDX_WIDTH-1:0]];
    assign res_meta     = meta_q[cm_ptr[FTQ_IDX_WIDTH-1:0]];
    assign actual_taken = resolve_i.has_branch && resolve_i.is_taken;
    assign mispredict   = resolve_i.has_branch ?
                          (resolve_i.is_taken != res_blk.predicted_taken) :
                          res_blk.predicted_taken;

    always_comb begin
        train_o.valid       = resolve_start;
        train_o.is_taken    = actual_taken;
        train_o.ctr         = res_meta.ctr;
        train_o.ftb_hit     = res_meta.ftb_hit;
        train_o.mispredict  = mispredict;
        train_o.redirect_pc = actual_taken ? resolve_i.target : next_line(res_blk.start_pc);
        // Without a resolved branch the stored branch trains toward not-taken
        train_o.branch_pc   = resolve_i.has_branch ? resolve_i.branch_pc : res_meta.branch_pc;
        train_o.target      = resolve_i.has_branch ? resolve_i.target : res_meta.target;
    end

    always_comb begin
        fetch_blk_o       = blk_q[fe_ptr[FTQ_IDX_WIDTH-1:0]];
        fetch_blk_o.valid = fetch_req_o;
    end

    //////////////////////////////////////////////////
    // Pointers and handshakes
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr        <= '0;
            fe_ptr        <= '0;
            cm_ptr        <= '0;
            fetch_req_o   <= 1'b0;
            resolve_ack_o <= 1'b0;
        end else begin
            if (flush) begin
                wr_ptr <= cm_ptr + 1'b1;
                fe_ptr <= cm_ptr + 1'b1;
            end else begin
                if (blk_wr) wr_ptr <= wr_ptr + 1'b1;
                if (fetch_req_o && fetch_ack_i) fe_ptr <= fe_ptr + 1'b1;
            end
            if (resolve_start) cm_ptr <= cm_ptr + 1'b1;

            if (fetch_req_o && fetch_ack_i) begin
                fetch_req_o <= 1'b0;
            end else if (fetch_start) begin
                fetch_req_o <= 1'b1;
            end

            if (resolve_start) begin
                resolve_ack_o <= 1'b1;
            end else if (resolve_ack_o && !resolve_req_i) begin
                resolve_ack_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (blk_wr) begin
            blk_q[wr_ptr[FTQ_IDX_WIDTH-1:0]]  <= blk_i;
            meta_q[wr_ptr[FTQ_IDX_WIDTH-1:0]] <= meta_i;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build with Verilator from tb.f, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_frontend -f tb.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qF "** PASS **" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tb.f ====
hw/bpu_pkg.sv
hw/ftb.sv
hw/bimodal_predictor.sv
hw/bpu.sv
hw/ftq.sv
hw/frontend_top.sv
tb/tb_frontend.sv

// ==== tb/tb_frontend.sv ====
// Testbench for frontend_top. Plays the fetch and resolve consumer.
// Resolve requests are raised only right after a fetch handshake ends, so the
// queue never has a fetch request pending when a resolution starts.
// The reference model assumes all test addresses stay below 0x2000 without aliasing.
`timescale 1ns/1ps
`default_nettype none

module tb_frontend
    import bpu_pkg::*;
;
    localparam int WAIT_LIMIT = 200;

    logic         clk;
    logic         rst_n;
    logic         fetch_ack;
    logic         resolve_req;
    resolve_t     resolve;
    logic         fetch_req;
    logic         resolve_ack;
    fetch_block_t fetch_blk;

    // Reference model of trained branches and counters per line
    logic        m_ftb_v [256];
    logic [31:0] m_br    [256];
    logic [31:0] m_tgt   [256];
    logic [1:0]  m_ctr   [256];
    logic [31:0] exp_pc;
    logic [7:0]  lfsr_state;
    int          errors;
    int          checks;
    int          tests_run;

    frontend_top dut (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .fetch_req_o   (fetch_req),
        .fetch_ack_i   (fetch_ack),
        .fetch_blk_o   (fetch_blk),
        .resolve_req_i (resolve_req),
        .resolve_i     (resolve),
        .resolve_ack_o (resolve_ack)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // Handshake rules
    //////////////////////////////////////////////////
    task automatic protocol_error(input string msg);
        errors++;
        $display("protocol error at %0t: %s", $time, msg);
    endtask

    assert property (@(posedge clk) disable iff (!rst_n) $rose(fetch_req) |-> !$past(fetch_ack))
        else protocol_error("fetch request rose while ack was still high");
    assert property (@(posedge clk) disable iff (!rst_n) $fell(fetch_req) |-> $past(fetch_ack))
        else protocol_error("fetch request dropped without an ack");
    assert property (@(posedge clk) disable iff (!rst_n)
                     (fetch_req && $past(fetch_req)) |-> $stable(fetch_blk))
        else protocol_error("fetch block changed while the request was high");
    assert property (@(posedge clk) disable iff (!rst_n) $rose(resolve_ack) |-> $past(resolve_req))
        else protocol_error("resolve ack rose without a request");
    assert property (@(posedge clk) disable iff (!rst_n) $fell(resolve_ack) |-> !$past(resolve_req))
        else protocol_error("resolve ack dropped while the request was high");

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic int line_idx(input logic [31:0] pc);
        line_idx = int'(pc[11:4]);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $finish;
    endtask

    // Wait until sig matches level, sampled on rising edges
    task automatic wait_level(ref logic sig, input logic level, input string what);
        int cnt;
        cnt = 0;
        @(posedge clk);
        while (sig !== level) begin
            if (cnt == WAIT_LIMIT) abort_run({"timeout waiting for ", what});
            cnt++;
            @(posedge clk);
        end
    endtask

    // Expected block for a start PC under the current model state
    task automatic predict_block(input logic [31:0] pc, output fetch_block_t b, output logic hit);
        int li;
        int ss;
        int bs;
        li  = line_idx(pc);
        ss  = int'(pc[3:2]);
        bs  = int'(m_br[li][3:2]);
        hit = m_ftb_v[li] && (bs >= ss);
        b.valid           = 1'b1;
        b.start_pc        = pc;
        b.predicted_taken = hit && (m_ctr[li] >= 2'd2);
        if (b.predicted_taken) begin
            b.length  = BLK_LEN_WIDTH'(bs - ss + 1);
            b.next_pc = m_tgt[li];
        end else begin
            b.length  = BLK_LEN_WIDTH'(4 - ss);
            b.next_pc = {pc[31:4] + 28'd1, 4'd0};
        end
    endtask

    task automatic fetch_one(output fetch_block_t got);
        int dly;
        wait_level(fetch_req, 1'b1, "fetch request");
        got = fetch_blk;
        rand_bits(2, dly);
        repeat (dly) @(posedge clk);
        fetch_ack <= 1'b1;
        wait_level(fetch_req, 1'b0, "fetch request to drop");
        fetch_ack <= 1'b0;
    endtask

    task automatic resolve_one(input resolve_t r);
        resolve_req <= 1'b1;
        resolve     <= r;
        wait_level(resolve_ack, 1'b1, "resolve ack");
        resolve_req <= 1'b0;
        wait_level(resolve_ack, 1'b0, "resolve ack to drop");
    endtask

    task automatic check_block(input fetch_block_t got, input fetch_block_t exp_blk);
        checks++;
        assert (got === exp_blk) else begin
            errors++;
            $display("mismatch at %0t: block %h len %0d taken %0b next %h, expected %h %0d %0b %h",
                     $time, got.start_pc, got.length, got.predicted_taken, got.next_pc,
                     exp_blk.start_pc, exp_blk.length, exp_blk.predicted_taken, exp_blk.next_pc);
        end
    endtask

    // Mode 0 resolves as predicted, 1 uses the given outcome, 2 flips the prediction
    task automatic step(input int mode, input logic has_br, input logic [31:0] br_pc,
                        input logic taken, input logic [31:0] tgt);
        fetch_block_t exp_blk;
        fetch_block_t got;
        resolve_t     r;
        logic         hit;
        logic         act;
        logic         misp;
        logic [31:0]  tbp;
        logic [1:0]   c;
        int           li;
        int           ti;
        int           slot;
        li = line_idx(exp_pc);
        predict_block(exp_pc, exp_blk, hit);
        fetch_one(got);
        check_block(got, exp_blk);
        if (mode == 1) begin
            r = {has_br, br_pc, taken, tgt};
        end else if (mode == 2 && exp_blk.predicted_taken) begin
            r = {1'b1, m_br[li], 1'b0, m_tgt[li]};
        end else if (mode == 2) begin
            rand_bits(2, slot);
            if (slot < int'(exp_pc[3:2])) slot = int'(exp_pc[3:2]);
            r = {1'b1, exp_pc[31:4], 2'(slot), 2'b00, 1'b1, tgt};
        end else begin
            r = {exp_blk.predicted_taken, m_br[li], exp_blk.predicted_taken, exp_blk.next_pc};
        end
        resolve_one(r);

        // Training rules
        act  = r.has_branch && r.is_taken;
        misp = r.has_branch ? (r.is_taken != exp_blk.predicted_taken) : exp_blk.predicted_taken;
        tbp  = r.has_branch ? r.branch_pc : m_br[li];
        ti   = line_idx(tbp);
        if (hit || misp) begin
            c = hit ? m_ctr[li] : CTR_WEAK_TAKEN;
            if (act) m_ctr[ti] = (c == 2'd3) ? 2'd3 : c + 2'd1;
            else     m_ctr[ti] = (c == 2'd0) ? 2'd0 : c - 2'd1;
        end
        if (misp) begin
            m_tgt[ti]   = r.has_branch ? r.target : m_tgt[li];
            m_ftb_v[ti] = 1'b1;
            m_br[ti]    = tbp;
            exp_pc      = act ? r.target : {exp_pc[31:4] + 28'd1, 4'd0};
        end else begin
            exp_pc = exp_blk.next_pc;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) $display("test %0d %s: passed", tests_run, name);
        else $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_before);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        logic [31:0] l_pc;
        logic [31:0] t_pc;
        logic [31:0] n_pc;
        int          e0;
        clk = 1'b0;
        rst_n = 1'b0;
        fetch_ack = 1'b0;
        resolve_req = 1'b0;
        resolve = '0;
        lfsr_state = 8'd13;
        errors = 0;
        checks = 0;
        tests_run = 0;
        exp_pc = RESET_PC;
        for (int i = 0; i < 256; i++) begin
            m_ftb_v[i] = 1'b0;
            m_br[i]    = '0;
            m_tgt[i]   = '0;
            m_ctr[i]   = CTR_WEAK_NOT_TAKEN;
        end
        repeat (2) @(posedge clk);
        checks++;
        assert (!fetch_req && !resolve_ack && !dut.blk.valid) else begin
            errors++;
            $display("mismatch at %0t: outputs not idle in reset", $time);
        end
        rst_n <= 1'b1;

        e0 = errors;
        repeat (4) step(0, 1'b0, '0, 1'b0, '0);
        end_test("reset and next-line sequence", e0);

        e0 = errors;
        repeat (6) step(0, 1'b0, '0, 1'b0, '0);
        end_test("four-phase handshakes", e0);

        // Branch in line l_pc jumps ahead to t_pc, which jumps back
        e0 = errors;
        l_pc = exp_pc;
        t_pc = l_pc + 32'h100;
        step(1, 1'b1, l_pc + 32'd8, 1'b1, t_pc);
        step(1, 1'b1, t_pc + 32'd12, 1'b1, l_pc);
        step(0, 1'b0, '0, 1'b0, '0);
        step(0, 1'b0, '0, 1'b0, '0);
        end_test("training and taken prediction", e0);

        e0 = errors;
        n_pc = l_pc + 32'd16;
        step(1, 1'b1, l_pc + 32'd8, 1'b0, t_pc);
        step(1, 1'b1, n_pc + 32'd12, 1'b1, l_pc);
        step(1, 1'b1, l_pc + 32'd8, 1'b0, t_pc);
        step(0, 1'b0, '0, 1'b0, '0);
        step(0, 1'b0, '0, 1'b0, '0);
        end_test("counter training", e0);

        e0 = errors;
        wait_level(dut.blk_ready, 1'b0, "queue full");
        repeat (10) step(0, 1'b0, '0, 1'b0, '0);
        end_test("back-pressure", e0);

        e0 = errors;
        wait_level(dut.blk_ready, 1'b0, "queue full before flush");
        step(2, 1'b0, '0, 1'b0, 32'h0000_1200);
        repeat (3) step(0, 1'b0, '0, 1'b0, '0);
        // Flipping a not-taken block redirects to the branch target
        step(2, 1'b0, '0, 1'b0, 32'h0000_1200);
        repeat (2) step(0, 1'b0, '0, 1'b0, '0);
        end_test("mispredict flush", e0);

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
